// File: flist.f
verilog/debug_pkg.sv
verilog/debug_snapshot.sv
verilog/debug_byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/debug_monitor.sv
sim/debug_monitor_chk.sv
sim/debug_monitor_scoreboard.sv
sim/debug_monitor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the debug monitor testbench with verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=debug_monitor_sim
LOG_FILE=sim.log

if ! verilator --binary --timing --assert -f flist.f \
        --top-module debug_monitor_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** PASSED ***' "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG_FILE"
exit 1

// File: sim/debug_monitor_tb.sv
/* testbench top: clock, reset, stimulus table loop, serial command
   driver and the closing verdict */
`default_nettype none

module debug_monitor_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_WIDTH    = 16;
    localparam int DIVIDER_TICKS = 200;
    localparam int TICKS_PER_BIT = 4;
    localparam int FIFO_DEPTH    = 4;
    localparam int NUM_ROWS      = 8;
    localparam int WAIT_LIMIT    = 2 * DIVIDER_TICKS;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] word;
        logic [7:0]            cmd;
        logic                  stop_bit;
        // set when a valid pulse is expected, clear for an error pulse
        logic                  cmd_ok;
    } row_t;

    logic                  clk_in;
    logic                  reset;
    logic [DATA_WIDTH-1:0] status_word;
    logic                  rx_line;
    logic                  tx_line;
    logic                  snapshot_busy;
    debug_pkg::byte_t      cmd_data;
    logic                  cmd_valid;
    logic                  cmd_error;
    logic                  word_push;
    logic                  cmd_push;
    debug_pkg::byte_t      cmd_byte;
    logic                  cmd_ok;
    int                    sb_errors;
    int                    pending;
    row_t                  table_rows [NUM_ROWS];
    logic [31:0]           rnd;
    int                    seed;
    int                    r;
    int                    tb_errors;
    logic                  timed_out;
    logic                  report_done;

    initial clk_in = 1'b0;
    always #10 clk_in = ~clk_in;

    debug_monitor #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DIVIDER_TICKS(DIVIDER_TICKS),
        .TICKS_PER_BIT(TICKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) debug_monitor_i (
        .clk_in         (clk_in),
        .reset          (reset),
        .i_data         (status_word),
        .i_rx           (rx_line),
        .o_tx           (tx_line),
        .o_snapshot_busy(snapshot_busy),
        .o_cmd_data     (cmd_data),
        .o_cmd_valid    (cmd_valid),
        .o_cmd_error    (cmd_error)
    );

    debug_monitor_scoreboard #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DIVIDER_TICKS(DIVIDER_TICKS),
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) scoreboard_i (
        .clk_in         (clk_in),
        .reset          (reset),
        .i_tx           (tx_line),
        .i_snapshot_busy(snapshot_busy),
        .i_cmd_data     (cmd_data),
        .i_cmd_valid    (cmd_valid),
        .i_cmd_error    (cmd_error),
        .i_word_push    (word_push),
        .i_word         (status_word),
        .i_cmd_push     (cmd_push),
        .i_cmd_byte     (cmd_byte),
        .i_cmd_ok       (cmd_ok),
        .o_errors       (sb_errors),
        .o_pending      (pending)
    );

    bind debug_monitor debug_monitor_chk debug_monitor_chk_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .i_frame_req(frame_req),
        .i_frame_ack(frame_ack),
        .i_in_frame (in_frame),
        .i_tx_req   (tx_req),
        .i_tx_ack   (tx_ack),
        .i_out_frame(out_frame),
        .i_tx       (o_tx),
        .i_tx_state (uart_tx_i.state)
    );

    // outputs are looked at on the falling edge, away from the register updates
    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (snapshot_busy !== level && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (snapshot_busy !== level) begin
            $display("timeout: o_snapshot_busy did not go %s", level ? "high" : "low");
            tb_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_pending_clear(input int limit);
        int n;
        n = 0;
        while (pending != 0 && n < limit) begin
            @(negedge clk_in);
            n++;
        end
        if (pending != 0) begin
            $display("timeout: %0d expected bytes or commands never showed up", pending);
            tb_errors++;
            timed_out = 1'b1;
        end
    endtask

    // start bit, eight data bits lsb first, then the given stop bit
    task automatic send_command(input debug_pkg::byte_t value, input logic stop_bit);
        logic [9:0] frame_bits;
        int         b;
        frame_bits = {stop_bit, value, 1'b0};
        for (b = 0; b < 10; b++) begin
            rx_line <= frame_bits[b];
            repeat (TICKS_PER_BIT) @(posedge clk_in);
        end
        rx_line <= 1'b1;
    endtask

    initial begin
        seed        = 6801;
        tb_errors   = 0;
        timed_out   = 1'b0;
        report_done = 1'b0;
        reset       = 1'b1;
        status_word = '0;
        rx_line     = 1'b1;
        word_push   = 1'b0;
        cmd_push    = 1'b0;
        cmd_byte    = '0;
        cmd_ok      = 1'b0;

        table_rows[0] = {16'h0000, 8'h00, 1'b1, 1'b1};
        table_rows[1] = {16'hFFFF, 8'hFF, 1'b1, 1'b1};
        table_rows[2] = {16'h0A0A, 8'h0A, 1'b0, 1'b0};
        table_rows[3] = {16'hA55A, 8'hC3, 1'b1, 1'b1};
        for (r = 4; r < NUM_ROWS; r++) begin
            rnd = $random(seed);
            table_rows[r] = {rnd[15:0], rnd[23:16], rnd[24], rnd[24]};
        end

        repeat (8) @(posedge clk_in);
        reset <= 1'b0;

        for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
            @(posedge clk_in);
            status_word <= table_rows[r].word;
            word_push   <= 1'b1;
            @(posedge clk_in);
            word_push <= 1'b0;
            // word stays put until the snapshot has been framed
            wait_busy(1'b1);
            wait_busy(1'b0);
            @(posedge clk_in);
            cmd_byte <= table_rows[r].cmd;
            cmd_ok   <= table_rows[r].cmd_ok;
            cmd_push <= 1'b1;
            @(posedge clk_in);
            cmd_push <= 1'b0;
            send_command(table_rows[r].cmd, table_rows[r].stop_bit);
            wait_pending_clear(WAIT_LIMIT);
        end
        @(negedge clk_in);

        report_done = 1'b1;
        $display("errors: %0d in scoreboard, %0d in testbench", sb_errors, tb_errors);
        if (sb_errors == 0 && tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // run stopped early, e.g. by a failed assertion
    final begin
        if (!report_done) begin
            $display("*** FAILED ***");
        end
    end

endmodule

`default_nettype wire

// File: sim/debug_monitor_scoreboard.sv
/* scoreboard: decodes o_tx characters, checks bytes, bit timing,
   reset state, first snapshot time and command pulses */
`default_nettype none

module debug_monitor_scoreboard #(
    parameter int DATA_WIDTH    = 16,
    parameter int DIVIDER_TICKS = 200,
    parameter int TICKS_PER_BIT = 4
) (
    input  wire                    clk_in,
    input  wire                    reset,
    input  wire                    i_tx,
    input  wire                    i_snapshot_busy,
    input  wire debug_pkg::byte_t  i_cmd_data,
    input  wire                    i_cmd_valid,
    input  wire                    i_cmd_error,
    input  wire                    i_word_push,
    input  wire [DATA_WIDTH-1:0]   i_word,
    input  wire                    i_cmd_push,
    input  wire debug_pkg::byte_t  i_cmd_byte,
    input  wire                    i_cmd_ok,
    output int                     o_errors,
    output int                     o_pending
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_BYTES  = DATA_WIDTH / 8;
    localparam int CHAR_TICKS = 10 * TICKS_PER_BIT;

    debug_pkg::byte_t exp_bytes [$];
    // {expect valid, byte}
    logic [8:0]       exp_cmds [$];
    debug_pkg::byte_t exp_byte;
    logic [8:0]       exp_cmd;
    logic [9:0]       char_bits;
    logic             tx_prev;
    logic             busy_prev;
    logic             in_char;
    logic             after_reset;
    logic             first_busy;
    int               t;
    int               cyc;
    int               i;
    int               err_count;

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("[ERROR] %s: expected 0x%0h, got 0x%0h at %0t", name, exp_val, got_val, $time);
        err_count++;
    endtask

    task automatic report_fault(input string what);
        $display("error at %0t: %s", $time, what);
        err_count++;
    endtask

    always @(posedge clk_in) begin
        if (reset) begin
            cyc         = 0;
            t           = 0;
            tx_prev     = 1'b1;
            busy_prev   = 1'b0;
            in_char     = 1'b0;
            after_reset = 1'b1;
            first_busy  = 1'b1;
            err_count   = 0;
        end else begin
            if (after_reset) begin
                after_reset = 1'b0;
                if (i_tx !== 1'b1) report_mismatch("o_tx after reset", 32'h1, 32'(i_tx));
                if (i_snapshot_busy !== 1'b0)
                    report_mismatch("o_snapshot_busy after reset", 32'h0, 32'(i_snapshot_busy));
                if (i_cmd_valid !== 1'b0)
                    report_mismatch("o_cmd_valid after reset", 32'h0, 32'(i_cmd_valid));
                if (i_cmd_error !== 1'b0)
                    report_mismatch("o_cmd_error after reset", 32'h0, 32'(i_cmd_error));
            end

            // first tick lands DIVIDER_TICKS cycles after reset, busy one cycle later
            if (i_snapshot_busy && !busy_prev && first_busy) begin
                first_busy = 1'b0;
                if (cyc != DIVIDER_TICKS)
                    report_mismatch("o_snapshot_busy first rise cycle", DIVIDER_TICKS, cyc);
            end
            busy_prev = i_snapshot_busy;

            if (!in_char) begin
                if (tx_prev && !i_tx) begin
                    in_char = 1'b1;
                    t       = 0;
                end else if (!i_tx) begin
                    report_fault("o_tx low outside a character");
                end
            end else begin
                t = t + 1;
                if (i_tx != tx_prev && (t % TICKS_PER_BIT) != 0)
                    report_fault("o_tx changed in the middle of a bit");
                if (t % TICKS_PER_BIT == TICKS_PER_BIT / 2)
                    char_bits[t / TICKS_PER_BIT] = i_tx;
                if (t == CHAR_TICKS - 1) begin
                    in_char = 1'b0;
                    if (char_bits[0] !== 1'b0 || char_bits[9] !== 1'b1)
                        report_fault("o_tx character with a bad start or stop bit");
                    if (exp_bytes.size() == 0) begin
                        report_fault("o_tx sent a byte that no snapshot accounts for");
                    end else begin
                        exp_byte = exp_bytes.pop_front();
                        if (char_bits[8:1] !== exp_byte)
                            report_mismatch("o_tx byte", 32'(exp_byte), 32'(char_bits[8:1]));
                    end
                end
            end
            tx_prev = i_tx;

            if (i_cmd_valid || i_cmd_error) begin
                if (exp_cmds.size() == 0) begin
                    report_fault("command pulse with no command byte sent");
                end else begin
                    exp_cmd = exp_cmds.pop_front();
                    if (i_cmd_valid !== exp_cmd[8])
                        report_mismatch("o_cmd_valid", 32'(exp_cmd[8]), 32'(i_cmd_valid));
                    if (i_cmd_error !== !exp_cmd[8])
                        report_mismatch("o_cmd_error", 32'(!exp_cmd[8]), 32'(i_cmd_error));
                    if (exp_cmd[8] && i_cmd_data !== exp_cmd[7:0])
                        report_mismatch("o_cmd_data", 32'(exp_cmd[7:0]), 32'(i_cmd_data));
                end
            end

            // one snapshot is its bytes msb first, then the newline
            if (i_word_push) begin
                for (i = NUM_BYTES - 1; i >= 0; i--) begin
                    exp_bytes.push_back(i_word[8*i +: 8]);
                end
                exp_bytes.push_back(debug_pkg::NEWLINE_BYTE);
            end
            if (i_cmd_push) exp_cmds.push_back({i_cmd_ok, i_cmd_byte});
            cyc = cyc + 1;
        end
        o_errors  <= err_count;
        o_pending <= exp_bytes.size() + exp_cmds.size();
    end

endmodule

`default_nettype wire

// File: sim/debug_monitor_chk.sv
/* four-phase handshake and idle-line assertions for the debug monitor */
`default_nettype none

module debug_monitor_chk (
    input wire                        clk_in,
    input wire                        reset,
    input wire                        i_frame_req,
    input wire                        i_frame_ack,
    input wire debug_pkg::tx_frame_t  i_in_frame,
    input wire                        i_tx_req,
    input wire                        i_tx_ack,
    input wire debug_pkg::tx_frame_t  i_out_frame,
    input wire                        i_tx,
    input wire [1:0]                  i_tx_state
);

    timeunit 1ns;
    timeprecision 100ps;

    // a new request may only start once the previous ack has cleared
    assert property (@(posedge clk_in) disable iff (reset) $rose(i_frame_req) |-> !i_frame_ack)
        else $error("frame_req rose while frame_ack was high");
    assert property (@(posedge clk_in) disable iff (reset) $rose(i_tx_req) |-> !i_tx_ack)
        else $error("tx_req rose while tx_ack was high");

    // payload held steady for the whole request
    assert property (@(posedge clk_in) disable iff (reset) i_frame_req |-> $stable(i_in_frame))
        else $error("in_frame changed while frame_req was high");
    assert property (@(posedge clk_in) disable iff (reset) i_tx_req |-> $stable(i_out_frame))
        else $error("out_frame changed while tx_req was high");

    // ack returns low only after req is already low
    assert property (@(posedge clk_in) disable iff (reset) $fell(i_frame_ack) |-> !i_frame_req)
        else $error("frame_ack fell while frame_req was still high");
    assert property (@(posedge clk_in) disable iff (reset) $fell(i_tx_ack) |-> !i_tx_req)
        else $error("tx_ack fell while tx_req was still high");

    assert property (@(posedge clk_in) disable iff (reset)
        (i_tx_state == debug_pkg::UART_IDLE) |-> i_tx)
        else $error("o_tx low while the transmitter is idle");

endmodule

`default_nettype wire

// File: verilog/debug_monitor.sv
/* debug monitor top: snapshot framer, frame fifo, uart tx and uart rx */
`default_nettype none

module debug_monitor #(
    parameter int DATA_WIDTH    = 32,
    parameter int DIVIDER_TICKS = 100000,
    parameter int TICKS_PER_BIT = 868,
    parameter int FIFO_DEPTH    = 4
) (
    input  wire                   clk_in,
    input  wire                   reset,
    input  wire [DATA_WIDTH-1:0]  i_data,
    input  wire                   i_rx,
    output logic                  o_tx,
    output logic                  o_snapshot_busy,
    output debug_pkg::byte_t      o_cmd_data,
    output logic                  o_cmd_valid,
    output logic                  o_cmd_error
);

    // snapshot -> fifo link
    logic                 frame_req;
    logic                 frame_ack;
    debug_pkg::tx_frame_t in_frame;
    // fifo -> transmitter link
    logic                 tx_req;
    logic                 tx_ack;
    debug_pkg::tx_frame_t out_frame;

    debug_snapshot #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DIVIDER_TICKS(DIVIDER_TICKS)
    ) debug_snapshot_i (
        .clk_in         (clk_in),
        .reset          (reset),
        .i_data         (i_data),
        .i_frame_ack    (frame_ack),
        .o_frame_req    (frame_req),
        .o_frame        (in_frame),
        .o_snapshot_busy(o_snapshot_busy)
    );

    debug_byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) debug_byte_fifo_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .i_frame_req(frame_req),
        .i_frame    (in_frame),
        .i_tx_ack   (tx_ack),
        .o_frame_ack(frame_ack),
        .o_tx_req   (tx_req),
        .o_tx_frame (out_frame)
    );

    uart_tx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) uart_tx_i (
        .clk_in    (clk_in),
        .reset     (reset),
        .i_tx_req  (tx_req),
        .i_tx_frame(out_frame),
        .o_tx_ack  (tx_ack),
        .o_tx      (o_tx)
    );

    uart_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) uart_rx_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .i_rx       (i_rx),
        .o_cmd_data (o_cmd_data),
        .o_cmd_valid(o_cmd_valid),
        .o_cmd_error(o_cmd_error)
    );

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
/* 8N1 uart receiver with input synchronizer, mid-bit sampling
   and stop-bit check, one-cycle valid or error pulse */
`default_nettype none

module uart_rx #(
    // needs at least 2 for the half-bit recheck
    parameter int TICKS_PER_BIT = 868
) (
    input  wire               clk_in,
    input  wire               reset,
    input  wire               i_rx,
    output debug_pkg::byte_t  o_cmd_data,
    output logic              o_cmd_valid,
    output logic              o_cmd_error
);

    localparam int SYNC_STAGES = 2;
    localparam int CNT_W       = $clog2(TICKS_PER_BIT + 1);
    localparam int HALF_TICKS  = TICKS_PER_BIT / 2;

    logic [SYNC_STAGES-1:0] sync;
    logic                   rx_s;
    logic                   rx_prev;
    debug_pkg::uart_state_e state;
    logic [CNT_W-1:0]       tick_cnt;
    logic [2:0]             bit_idx;
    debug_pkg::byte_t       shreg;
    logic                   bit_mid;

    assign rx_s    = sync[SYNC_STAGES-1];
    assign bit_mid = (tick_cnt == CNT_W'(TICKS_PER_BIT - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            sync        <= '1;
            rx_prev     <= 1'b1;
            state       <= debug_pkg::UART_IDLE;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            o_cmd_valid <= 1'b0;
            o_cmd_error <= 1'b0;
        end else begin
            sync        <= {sync[SYNC_STAGES-2:0], i_rx};
            rx_prev     <= rx_s;
            o_cmd_valid <= 1'b0;
            o_cmd_error <= 1'b0;
            tick_cnt    <= bit_mid ? '0 : tick_cnt + 1'b1;

            case (state)
                debug_pkg::UART_IDLE: begin
                    tick_cnt <= '0;
                    // falling edge only, a line stuck low after a bad stop bit is ignored
                    if (rx_prev && !rx_s) begin
                        state <= debug_pkg::UART_START;
                    end
                end
                debug_pkg::UART_START: begin
                    if (tick_cnt == CNT_W'(HALF_TICKS - 1)) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        // glitch filter: start bit must still be low at half a bit
                        state    <= rx_s ? debug_pkg::UART_IDLE : debug_pkg::UART_DATA;
                    end
                end
                debug_pkg::UART_DATA: begin
                    if (bit_mid) begin
                        shreg   <= {rx_s, shreg[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= debug_pkg::UART_STOP;
                        end
                    end
                end
                debug_pkg::UART_STOP: begin
                    if (bit_mid) begin
                        o_cmd_valid <= rx_s;
                        o_cmd_error <= !rx_s;
                        state       <= debug_pkg::UART_IDLE;
                    end
                end
                default: state <= debug_pkg::UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == debug_pkg::UART_STOP && bit_mid && rx_s) begin
            o_cmd_data <= shreg;
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
/* 8N1 uart transmitter fed by frames over four-phase req/ack */
`default_nettype none

module uart_tx #(
    parameter int TICKS_PER_BIT = 868
) (
    input  wire                    clk_in,
    input  wire                    reset,
    input  wire                    i_tx_req,
    input  debug_pkg::tx_frame_t   i_tx_frame,
    output logic                   o_tx_ack,
    output logic                   o_tx
);

    localparam int CNT_W = $clog2(TICKS_PER_BIT + 1);

    debug_pkg::uart_state_e state;
    logic [CNT_W-1:0]       tick_cnt;
    logic [2:0]             bit_idx;
    debug_pkg::byte_t       shreg;
    logic                   bit_end;

    assign bit_end = (tick_cnt == CNT_W'(TICKS_PER_BIT - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state    <= debug_pkg::UART_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            o_tx_ack <= 1'b0;
            o_tx     <= 1'b1;
        end else begin
            // ack follows req back down, independent of the serializer
            if (o_tx_ack && !i_tx_req) begin
                o_tx_ack <= 1'b0;
            end
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;

            case (state)
                debug_pkg::UART_IDLE: begin
                    o_tx     <= 1'b1;
                    tick_cnt <= '0;
                    if (i_tx_req && !o_tx_ack) begin
                        shreg    <= i_tx_frame.data;
                        o_tx_ack <= 1'b1;
                        o_tx     <= 1'b0;
                        state    <= debug_pkg::UART_START;
                    end
                end
                debug_pkg::UART_START: begin
                    if (bit_end) begin
                        o_tx    <= shreg[0];
                        shreg   <= shreg >> 1;
                        bit_idx <= '0;
                        state   <= debug_pkg::UART_DATA;
                    end
                end
                debug_pkg::UART_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1;
                            state <= debug_pkg::UART_STOP;
                        end else begin
                            o_tx    <= shreg[0];
                            shreg   <= shreg >> 1;
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                debug_pkg::UART_STOP: begin
                    if (bit_end) begin
                        state <= debug_pkg::UART_IDLE;
                    end
                end
                default: state <= debug_pkg::UART_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/debug_byte_fifo.sv
/* circular frame buffer between two four-phase req/ack links,
   slave on the write side and master on the read side */
`default_nettype none

module debug_byte_fifo #(
    // power of two, at least 2
    parameter int FIFO_DEPTH = 4
) (
    input  wire                    clk_in,
    input  wire                    reset,
    input  wire                    i_frame_req,
    input  debug_pkg::tx_frame_t   i_frame,
    input  wire                    i_tx_ack,
    output logic                   o_frame_ack,
    output logic                   o_tx_req,
    output debug_pkg::tx_frame_t   o_tx_frame
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    debug_pkg::tx_frame_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full = (count == CNT_W'(FIFO_DEPTH));
    // req seen while ack still low is a new frame; a full buffer holds off the ack
    assign push = i_frame_req && !o_frame_ack && !full;
    // pop on the rising ack from the transmitter
    assign pop  = o_tx_req && i_tx_ack;

    assign o_tx_frame = mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= i_frame;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            o_frame_ack <= 1'b0;
            o_tx_req    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr      <= wr_ptr + 1'b1;
                o_frame_ack <= 1'b1;
            end else if (!i_frame_req) begin
                o_frame_ack <= 1'b0;
            end

            if (pop) begin
                rd_ptr   <= rd_ptr + 1'b1;
                o_tx_req <= 1'b0;
            end else if (!o_tx_req && !i_tx_ack && count != '0) begin
                o_tx_req <= 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/debug_snapshot.sv
/* periodic status snapshot and byte framer, msb first plus newline,
   handing frames out over a four-phase req/ack link */
`default_nettype none

module debug_snapshot #(
    parameter int DATA_WIDTH    = 32,
    parameter int DIVIDER_TICKS = 100000
) (
    input  wire                    clk_in,
    input  wire                    reset,
    input  wire [DATA_WIDTH-1:0]   i_data,
    input  wire                    i_frame_ack,
    output logic                   o_frame_req,
    output debug_pkg::tx_frame_t   o_frame,
    output logic                   o_snapshot_busy
);

    localparam int NUM_BYTES = DATA_WIDTH / 8;
    localparam int DIV_W     = $clog2(DIVIDER_TICKS + 1);
    // counts NUM_BYTES down to 0, where 0 selects the newline
    localparam int IDX_W     = $clog2(NUM_BYTES + 1);

    logic [DIV_W-1:0]        period_cnt;
    logic                    tick;
    logic [DATA_WIDTH-1:0]   snap_word;
    logic [IDX_W-1:0]        byte_cnt;
    debug_pkg::snap_state_e  state;

    assign tick = (period_cnt == DIV_W'(DIVIDER_TICKS - 1));

    always_ff @(posedge clk_in) begin
        if (reset || tick) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // snapshot register only loads from idle, so it is never overwritten mid-frame
    always_ff @(posedge clk_in) begin
        if (state == debug_pkg::SNAP_IDLE && tick) begin
            snap_word <= i_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == debug_pkg::SNAP_LOAD) begin
            if (byte_cnt == '0) begin
                o_frame.data <= debug_pkg::NEWLINE_BYTE;
                o_frame.last <= 1'b1;
            end else begin
                o_frame.data <= snap_word[8*byte_cnt-1 -: 8];
                o_frame.last <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state           <= debug_pkg::SNAP_IDLE;
            byte_cnt        <= '0;
            o_frame_req     <= 1'b0;
            o_snapshot_busy <= 1'b0;
        end else begin
            case (state)
                debug_pkg::SNAP_IDLE: begin
                    // ticks outside idle are simply dropped
                    if (tick) begin
                        byte_cnt        <= IDX_W'(NUM_BYTES);
                        o_snapshot_busy <= 1'b1;
                        state           <= debug_pkg::SNAP_LOAD;
                    end
                end
                debug_pkg::SNAP_LOAD: begin
                    state <= debug_pkg::SNAP_REQ;
                end
                debug_pkg::SNAP_REQ: begin
                    // frame was registered a cycle earlier, so it is stable here
                    if (!o_frame_req) begin
                        o_frame_req <= 1'b1;
                    end else if (i_frame_ack) begin
                        o_frame_req <= 1'b0;
                        if (o_frame.last) begin
                            o_snapshot_busy <= 1'b0;
                        end
                        state <= debug_pkg::SNAP_RELEASE;
                    end
                end
                debug_pkg::SNAP_RELEASE: begin
                    // wait for ack low before the next req
                    if (!i_frame_ack) begin
                        if (o_frame.last) begin
                            state <= debug_pkg::SNAP_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                            state    <= debug_pkg::SNAP_LOAD;
                        end
                    end
                end
                default: state <= debug_pkg::SNAP_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/debug_pkg.sv
/* shared types for the debug monitor: serial byte, frame struct,
   state enums and the newline terminator */
`default_nettype none

package debug_pkg;

    // one byte on the serial line
    typedef logic [7:0] byte_t;

    // byte plus end-of-snapshot marker, passed snapshot -> fifo -> uart_tx
    typedef struct packed {
        byte_t data;
        logic  last;
    } tx_frame_t;

    // terminator sent after the last status byte
    localparam byte_t NEWLINE_BYTE = 8'h0A;

    // snapshot framer states
    typedef enum logic [1:0] {
        SNAP_IDLE,
        SNAP_LOAD,
        SNAP_REQ,
        SNAP_RELEASE
    } snap_state_e;

    // shared by the uart transmitter and receiver
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

`default_nettype wire
